//--- src.f
hw/core_data_pkg.sv
hw/data_sram.sv
hw/sram_arbiter.sv
hw/apb_bridge.sv
hw/core_req_router.sv
hw/core_data_top.sv
testbench/tb_clock_gen.sv
testbench/tb_core_data.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_data
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/10ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_core_data.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core_data;
    import core_data_pkg::*;

    localparam int NUM_ROWS      = 18;
    localparam int SAMPLE_DELAY  = 5;
    localparam int GROUP_TIMEOUT = 40;
    localparam int RESET_TIMEOUT = 40;
    localparam int APB_WORDS     = 16;

    typedef struct packed {
        logic [8*12-1:0] name;
        logic            ext;
        logic            pair;
        logic            we;
        addr_t           addr;
        be_t             be;
        data_t           wdata;
        data_t           rdata;
    } row_t;

    logic        clk;
    logic        reset_n;
    logic        core_req;
    mem_req_t    core_req_data;
    logic        core_gnt;
    mem_rsp_t    core_rsp;
    logic        ext_req;
    mem_req_t    ext_req_data;
    logic        ext_gnt;
    mem_rsp_t    ext_rsp;
    apb_req_t    apb_req;
    logic        psel;
    logic        penable;
    logic        pready = 1'b0;
    data_t       prdata = '0;

    row_t        rows [NUM_ROWS];
    data_t       sram_ref [SRAM_WORDS];
    data_t       apb_ref [APB_WORDS];
    data_t       apb_mem [APB_WORDS];
    apb_req_t    apb_exp = '0;
    logic        apb_exp_valid = 1'b0;
    logic        last_sram_ext = 1'b0;
    logic        last_sram_valid = 1'b0;
    logic [15:0] lfsr_q = 16'd15;
    logic [1:0]  wait_left = '0;
    logic        psel_prev = 1'b0;
    logic        penable_prev = 1'b0;
    int          value_errs = 0;
    int          protocol_errs = 0;
    int          timeouts = 0;

    tb_clock_gen clock_i (
        .clk_o    ( clk     ),
        .reset_no ( reset_n )
    );

    core_data_top dut_i (
        .clk_i           ( clk           ),
        .reset_ni        ( reset_n       ),
        .core_req_i      ( core_req      ),
        .core_req_data_i ( core_req_data ),
        .core_gnt_o      ( core_gnt      ),
        .core_rsp_o      ( core_rsp      ),
        .ext_req_i       ( ext_req       ),
        .ext_req_data_i  ( ext_req_data  ),
        .ext_gnt_o       ( ext_gnt       ),
        .ext_rsp_o       ( ext_rsp       ),
        .apb_req_o       ( apb_req       ),
        .psel_o          ( psel          ),
        .penable_o       ( penable       ),
        .pready_i        ( pready        ),
        .prdata_i        ( prdata        )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input be_t be);
        data_t res;
        int    b;
        res = old_word;
        for (b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic is_sram(input addr_t addr);
        return addr < SRAM_BASE + SRAM_SIZE;
    endfunction

    function automatic mem_req_t to_req(input row_t r);
        return '{addr: r.addr, we: r.we, be: r.be, wdata: r.wdata};
    endfunction

    function automatic string port_name(input int p);
        return (p == 1) ? "ext" : "core";
    endfunction

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // APB slave model and protocol monitor

    always @(negedge clk) begin
        if (!reset_n) begin
            pready = 1'b0;
        end else if (psel && !penable) begin
            lfsr_q = lfsr_step(lfsr_q);
            wait_left[0] = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
            wait_left[1] = lfsr_q[0];
            pready = 1'b0;
        end else if (psel && penable && wait_left != 0) begin
            wait_left = wait_left - 2'd1;
        end else if (psel && penable) begin
            pready = 1'b1;
            if (apb_req.pwrite) begin
                apb_mem[apb_req.paddr[5:2]] = merge_bytes(apb_mem[apb_req.paddr[5:2]],
                                                          apb_req.pwdata, apb_req.pstrb);
            end else begin
                prdata = apb_mem[apb_req.paddr[5:2]];
            end
        end else begin
            pready = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (reset_n) begin
            if (psel && apb_exp_valid && apb_req !== apb_exp) begin
                value_errs++;
                $display("Fail apb_request: expected %h, actual %h", apb_exp, apb_req);
            end
            // ACCESS only straight after one SETUP cycle
            if (penable && !penable_prev && !(psel_prev && !penable_prev)) begin
                protocol_errs++;
                $display("penable_o rose without a setup cycle before it");
            end
            if (psel && !penable && psel_prev && !penable_prev) begin
                protocol_errs++;
                $display("psel_o stayed in setup for more than one cycle");
            end
        end
        psel_prev    = psel;
        penable_prev = penable;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table

    task automatic load_table();
        rows[0]  = '{"sram_full", 1'b0, 1'b0, 1'b1, 32'h0000_0100, 4'hF, 32'h1122_3344, 32'h0};
        rows[1]  = '{"sram_part", 1'b0, 1'b0, 1'b1, 32'h0000_0100, 4'h5, 32'hAABB_CCDD, 32'h0};
        rows[2]  = '{"sram_read", 1'b0, 1'b0, 1'b0, 32'h0000_0100, 4'hF, 32'h0, 32'h11BB_33DD};
        rows[3]  = '{"apb_write", 1'b0, 1'b0, 1'b1, 32'h1000_0004, 4'h3, 32'hCAFE_BEEF, 32'h0};
        rows[4]  = '{"apb_read", 1'b0, 1'b0, 1'b0, 32'h1000_0004, 4'hF, 32'h0, 32'h4A5A_BEEF};
        rows[5]  = '{"apb_fill", 1'b0, 1'b0, 1'b0, 32'h1000_0008, 4'hF, 32'h0, 32'h4A5A_5A52};
        rows[6]  = '{"ext_write", 1'b1, 1'b0, 1'b1, 32'h0000_0200, 4'hF, 32'h0BAD_F00D, 32'h0};
        rows[7]  = '{"core_write", 1'b0, 1'b0, 1'b1, 32'h0000_0204, 4'hF, 32'h1357_9BDF, 32'h0};
        rows[8]  = '{"ext_rd_core", 1'b1, 1'b0, 1'b0, 32'h0000_0204, 4'hF, 32'h0, 32'h1357_9BDF};
        // Pairs start on the same cycle
        rows[9]  = '{"pair1_core", 1'b0, 1'b1, 1'b1, 32'h0000_0300, 4'hF, 32'hDEAD_0001, 32'h0};
        rows[10] = '{"pair1_ext", 1'b1, 1'b0, 1'b1, 32'h0000_0304, 4'hF, 32'hDEAD_0002, 32'h0};
        rows[11] = '{"pair2_core", 1'b0, 1'b1, 1'b0, 32'h0000_0304, 4'hF, 32'h0, 32'hDEAD_0002};
        rows[12] = '{"pair2_ext", 1'b1, 1'b0, 1'b0, 32'h0000_0300, 4'hF, 32'h0, 32'hDEAD_0001};
        // Core granted last so ext wins the next pairs
        rows[13] = '{"core_rd_ext", 1'b0, 1'b0, 1'b0, 32'h0000_0200, 4'hF, 32'h0, 32'h0BAD_F00D};
        rows[14] = '{"pair3_core", 1'b0, 1'b1, 1'b1, 32'h0000_0308, 4'hF, 32'h55AA_55AA, 32'h0};
        rows[15] = '{"pair3_ext", 1'b1, 1'b0, 1'b0, 32'h0000_0100, 4'hF, 32'h0, 32'h11BB_33DD};
        rows[16] = '{"pair4_core", 1'b0, 1'b1, 1'b0, 32'h0000_0308, 4'hF, 32'h0, 32'h55AA_55AA};
        rows[17] = '{"pair4_ext", 1'b1, 1'b0, 1'b1, 32'h0000_0300, 4'h8, 32'h7700_0000, 32'h0};
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Transfer engine

    task automatic check_response(input row_t r, input data_t rdata);
        int    idx;
        data_t predicted;
        if (is_sram(r.addr)) begin
            idx = int'(r.addr[SRAM_IDX_W+1:2]);
            predicted = sram_ref[idx];
            if (r.we) begin
                sram_ref[idx] = merge_bytes(predicted, r.wdata, r.be);
            end
        end else begin
            idx = int'(r.addr[5:2]);
            predicted = apb_ref[idx];
            if (r.we) begin
                apb_ref[idx] = merge_bytes(predicted, r.wdata, r.be);
            end
        end
        if (!r.we && rdata !== predicted) begin
            value_errs++;
            $display("Fail %0s: expected %h, actual %h", r.name, predicted, rdata);
        end else if (!r.we && rdata !== r.rdata) begin
            value_errs++;
            $display("Fail %0s: expected %h, actual %h", r.name, r.rdata, rdata);
        end
    endtask

    task automatic expect_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errs++;
            $display("Fail %0s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic run_group(input int first, input logic both);
        row_t       r [2];
        int         acc_cyc [2];
        int         rsp_cyc [2];
        logic [1:0] used;
        logic [1:0] pending;
        logic [1:0] waiting;
        logic       contested;
        logic       rv;
        data_t      rd;
        int         cyc;
        int         p;
        r[0] = '0;
        r[1] = '0;
        used = '0;
        acc_cyc[0] = 0;
        acc_cyc[1] = 0;
        rsp_cyc[0] = 0;
        rsp_cyc[1] = 0;
        r[rows[first].ext] = rows[first];
        used[rows[first].ext] = 1'b1;
        if (both) begin
            r[rows[first+1].ext] = rows[first+1];
            used[rows[first+1].ext] = 1'b1;
        end
        contested = used[0] && used[1] && is_sram(r[0].addr) && is_sram(r[1].addr);
        pending = used;
        waiting = '0;
        if (used[0] && !is_sram(r[0].addr)) begin
            apb_exp = '{paddr: r[0].addr, pwrite: r[0].we, pwdata: r[0].wdata, pstrb: r[0].be};
            apb_exp_valid = 1'b1;
        end

        cyc = 0;
        while ((pending != 0 || waiting != 0) && cyc < GROUP_TIMEOUT) begin
            @(negedge clk);
            core_req      = pending[0];
            core_req_data = pending[0] ? to_req(r[0]) : '0;
            ext_req       = pending[1];
            ext_req_data  = pending[1] ? to_req(r[1]) : '0;
            #SAMPLE_DELAY;
            if (core_rsp.rvalid && ext_rsp.rvalid && used[0] && is_sram(r[0].addr)) begin
                protocol_errs++;
                $display("Both masters got an SRAM response in the same cycle");
            end
            for (p = 0; p < 2; p++) begin
                rv = (p == 1) ? ext_rsp.rvalid : core_rsp.rvalid;
                rd = (p == 1) ? ext_rsp.rdata : core_rsp.rdata;
                if (rv && !waiting[p]) begin
                    protocol_errs++;
                    $display("Response on the %0s port with nothing outstanding", port_name(p));
                end else if (rv) begin
                    waiting[p] = 1'b0;
                    rsp_cyc[p] = cyc;
                    if (is_sram(r[p].addr)) begin
                        // Winner of a contested grant is the one not granted last
                        if (contested && (pending[1-p] || waiting[1-p]) && last_sram_valid
                                && last_sram_ext == (p == 1)) begin
                            protocol_errs++;
                            $display("The %0s port won twice in a row while the other waited",
                                     port_name(p));
                        end
                        last_sram_ext   = (p == 1);
                        last_sram_valid = 1'b1;
                    end
                    check_response(r[p], rd);
                end
            end
            if (pending[0] && core_gnt) begin
                pending[0] = 1'b0;
                waiting[0] = 1'b1;
                acc_cyc[0] = cyc;
            end
            if (pending[1] && ext_gnt) begin
                pending[1] = 1'b0;
                waiting[1] = 1'b1;
                acc_cyc[1] = cyc;
            end
            cyc++;
        end

        if (pending != 0 || waiting != 0) begin
            timeouts++;
            $display("Timeout: no grant or response for row %0s", rows[first].name);
        end else begin
            for (p = 0; p < 2; p++) begin
                if (used[p] && is_sram(r[p].addr) && (p == 1 || !contested)
                        && rsp_cyc[p] != acc_cyc[p] + 1) begin
                    value_errs++;
                    $display("Fail %0s: expected latency 1, actual %0d", r[p].name,
                             rsp_cyc[p] - acc_cyc[p]);
                end
            end
            if (contested && rsp_cyc[0] - rsp_cyc[1] != 1 && rsp_cyc[1] - rsp_cyc[0] != 1) begin
                protocol_errs++;
                $display("The losing master was not served right after the winner");
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int i;
        int n;
        core_req      = 1'b0;
        core_req_data = '0;
        ext_req       = 1'b0;
        ext_req_data  = '0;
        load_table();
        for (i = 0; i < SRAM_WORDS; i++) begin
            sram_ref[i] = 'x;
        end
        // APB fill depends on the full word address
        for (i = 0; i < APB_WORDS; i++) begin
            apb_ref[i] = (APB_BASE + addr_t'(4 * i)) ^ 32'h5A5A_5A5A;
            apb_mem[i] = apb_ref[i];
        end

        n = 0;
        while (!reset_n && n < RESET_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!reset_n) begin
            timeouts++;
            $display("Timeout: reset_ni was never released");
        end else begin
            @(negedge clk);
            #SAMPLE_DELAY;
            expect_bit("reset_psel", 1'b0, psel);
            expect_bit("reset_penable", 1'b0, penable);
            expect_bit("reset_core_rvalid", 1'b0, core_rsp.rvalid);
            expect_bit("reset_ext_rvalid", 1'b0, ext_rsp.rvalid);
            expect_bit("reset_core_gnt", 1'b1, core_gnt);
            expect_bit("reset_ext_gnt", 1'b0, ext_gnt);
        end

        i = 0;
        while (i < NUM_ROWS && timeouts == 0) begin
            if (rows[i].pair) begin
                run_group(i, 1'b1);
                i = i + 2;
            end else begin
                run_group(i, 1'b0);
                i = i + 1;
            end
        end

        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errs, protocol_errs, timeouts);
        if (value_errs + protocol_errs + timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_no
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_no = 1'b1;
    end

endmodule

`default_nettype wire

//--- hw/core_data_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_data_top (
    input  logic                     clk_i,
    input  logic                     reset_ni,

    input  logic                     core_req_i,
    input  core_data_pkg::mem_req_t  core_req_data_i,
    output logic                     core_gnt_o,
    output core_data_pkg::mem_rsp_t  core_rsp_o,

    input  logic                     ext_req_i,
    input  core_data_pkg::mem_req_t  ext_req_data_i,
    output logic                     ext_gnt_o,
    output core_data_pkg::mem_rsp_t  ext_rsp_o,

    output core_data_pkg::apb_req_t  apb_req_o,
    output logic                     psel_o,
    output logic                     penable_o,
    input  logic                     pready_i,
    input  core_data_pkg::data_t     prdata_i
);
    import core_data_pkg::*;

    // Router to SRAM arbiter
    logic     sram_req;
    mem_req_t sram_req_data;
    logic     sram_gnt;
    mem_rsp_t sram_rsp;

    // Router to APB bridge
    logic     apb_req;
    mem_req_t apb_req_data;
    logic     apb_gnt;
    mem_rsp_t apb_rsp;

    // Arbiter to memory
    logic     mem_req;
    mem_req_t mem_req_data;
    mem_rsp_t mem_rsp;

    ////////////////////////////////////////////////////////////////////////////
    // Core request path

    core_req_router router_i (
        .clk_i           ( clk_i           ),
        .reset_ni        ( reset_ni        ),
        .core_req_i      ( core_req_i      ),
        .core_req_data_i ( core_req_data_i ),
        .core_gnt_o      ( core_gnt_o      ),
        .core_rsp_o      ( core_rsp_o      ),
        .sram_req_o      ( sram_req        ),
        .sram_req_data_o ( sram_req_data   ),
        .sram_gnt_i      ( sram_gnt        ),
        .sram_rsp_i      ( sram_rsp        ),
        .apb_req_o       ( apb_req         ),
        .apb_req_data_o  ( apb_req_data    ),
        .apb_gnt_i       ( apb_gnt         ),
        .apb_rsp_i       ( apb_rsp         )
    );

    apb_bridge apb_i (
        .clk_i      ( clk_i        ),
        .reset_ni   ( reset_ni     ),
        .req_i      ( apb_req      ),
        .req_data_i ( apb_req_data ),
        .gnt_o      ( apb_gnt      ),
        .rsp_o      ( apb_rsp      ),
        .apb_req_o  ( apb_req_o    ),
        .psel_o     ( psel_o       ),
        .penable_o  ( penable_o    ),
        .pready_i   ( pready_i     ),
        .prdata_i   ( prdata_i     )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Shared SRAM

    sram_arbiter arbiter_i (
        .clk_i           ( clk_i          ),
        .reset_ni        ( reset_ni       ),
        .core_req_i      ( sram_req       ),
        .core_req_data_i ( sram_req_data  ),
        .core_gnt_o      ( sram_gnt       ),
        .core_rsp_o      ( sram_rsp       ),
        .ext_req_i       ( ext_req_i      ),
        .ext_req_data_i  ( ext_req_data_i ),
        .ext_gnt_o       ( ext_gnt_o      ),
        .ext_rsp_o       ( ext_rsp_o      ),
        .mem_req_o       ( mem_req        ),
        .mem_req_data_o  ( mem_req_data   ),
        .mem_rsp_i       ( mem_rsp        )
    );

    data_sram sram_i (
        .clk_i      ( clk_i        ),
        .reset_ni   ( reset_ni     ),
        .req_i      ( mem_req      ),
        .req_data_i ( mem_req_data ),
        .rsp_o      ( mem_rsp      )
    );

endmodule

`default_nettype wire

//--- hw/core_req_router.sv
`timescale 1ns/10ps
`default_nettype none

module core_req_router (
    input  logic                     clk_i,
    input  logic                     reset_ni,

    input  logic                     core_req_i,
    input  core_data_pkg::mem_req_t  core_req_data_i,
    output logic                     core_gnt_o,
    output core_data_pkg::mem_rsp_t  core_rsp_o,

    output logic                     sram_req_o,
    output core_data_pkg::mem_req_t  sram_req_data_o,
    input  logic                     sram_gnt_i,
    input  core_data_pkg::mem_rsp_t  sram_rsp_i,

    output logic                     apb_req_o,
    output core_data_pkg::mem_req_t  apb_req_data_o,
    input  logic                     apb_gnt_i,
    input  core_data_pkg::mem_rsp_t  apb_rsp_i
);
    import core_data_pkg::*;

    logic     busy_q;
    logic     issued_q;
    region_e  region_q;
    mem_req_t hold_q;

    logic     done;
    logic     live;
    logic     down_gnt;
    mem_req_t cur_req;
    region_e  cur_region;

    function automatic region_e decode_region(addr_t addr);
        region_e region;
        region = REGION_ILLEGAL;
        if ((addr - SRAM_BASE) < SRAM_SIZE) begin
            region = REGION_SRAM;
        end else if (addr >= APB_BASE && addr <= APB_LIMIT) begin
            region = REGION_APB;
        end
        return region;
    endfunction

    // Response comes from the region of the outstanding transfer
    always_comb begin
        case (region_q)
            REGION_APB: core_rsp_o = apb_rsp_i;
            default:    core_rsp_o = sram_rsp_i;
        endcase
    end

    assign done       = busy_q & core_rsp_o.rvalid;
    assign core_gnt_o = ~busy_q | done;

    // A fresh request bypasses the holding register
    assign cur_req    = core_gnt_o ? core_req_data_i : hold_q;
    assign cur_region = decode_region(cur_req.addr);
    assign live       = core_gnt_o ? core_req_i : ~issued_q;

    assign sram_req_o      = live && cur_region == REGION_SRAM;
    assign apb_req_o       = live && cur_region == REGION_APB;
    assign sram_req_data_o = cur_req;
    assign apb_req_data_o  = cur_req;
    assign down_gnt        = (sram_req_o & sram_gnt_i) | (apb_req_o & apb_gnt_i);

    always_ff @(posedge clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            busy_q   <= 1'b0;
            issued_q <= 1'b0;
            region_q <= REGION_SRAM;
        end else if (core_gnt_o) begin
            busy_q   <= core_req_i;
            issued_q <= down_gnt;
            if (core_req_i) begin
                region_q <= cur_region;
            end
        end else if (down_gnt) begin
            issued_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (core_gnt_o && core_req_i) begin
            hold_q <= core_req_data_i;
        end
    end

    a_legal_addr: assert property (@(posedge clk_i) disable iff (!reset_ni)
        live |-> cur_region != REGION_ILLEGAL)
        else $error("core_req_router: illegal address %h", cur_req.addr);

    // Downstream must never answer a transfer we did not issue
    a_rsp_outstanding: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (sram_rsp_i.rvalid || apb_rsp_i.rvalid) |-> busy_q && issued_q)
        else $error("core_req_router: response with nothing outstanding");

endmodule

`default_nettype wire

//--- hw/apb_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module apb_bridge (
    input  logic                     clk_i,
    input  logic                     reset_ni,

    input  logic                     req_i,
    input  core_data_pkg::mem_req_t  req_data_i,
    output logic                     gnt_o,
    output core_data_pkg::mem_rsp_t  rsp_o,

    output core_data_pkg::apb_req_t  apb_req_o,
    output logic                     psel_o,
    output logic                     penable_o,
    input  logic                     pready_i,
    input  core_data_pkg::data_t     prdata_i
);
    import core_data_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   rvalid_q;
    data_t  rdata_q;

    assign gnt_o     = state_q == IDLE;
    assign psel_o    = state_q != IDLE;
    assign penable_o = state_q == ACCESS;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (req_i) state_d = SETUP;
            SETUP:   state_d = ACCESS;
            // Wait states until the slave is ready
            ACCESS:  if (pready_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            state_q  <= IDLE;
            rvalid_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            rvalid_q <= penable_o & pready_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i && gnt_o) begin
            apb_req_o.paddr  <= req_data_i.addr;
            apb_req_o.pwrite <= req_data_i.we;
            apb_req_o.pwdata <= req_data_i.wdata;
            apb_req_o.pstrb  <= req_data_i.be;
        end
        if (penable_o && pready_i) begin
            rdata_q <= prdata_i;
        end
    end

    always_comb begin
        rsp_o.rvalid = rvalid_q;
        rsp_o.rdata  = rdata_q;
    end

    a_apb_stable: assert property (@(posedge clk_i) disable iff (!reset_ni)
        psel_o |=> !psel_o || $stable(apb_req_o))
        else $error("apb_bridge: APB request changed during transfer");

endmodule

`default_nettype wire

//--- hw/sram_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module sram_arbiter (
    input  logic                     clk_i,
    input  logic                     reset_ni,

    input  logic                     core_req_i,
    input  core_data_pkg::mem_req_t  core_req_data_i,
    output logic                     core_gnt_o,
    output core_data_pkg::mem_rsp_t  core_rsp_o,

    input  logic                     ext_req_i,
    input  core_data_pkg::mem_req_t  ext_req_data_i,
    output logic                     ext_gnt_o,
    output core_data_pkg::mem_rsp_t  ext_rsp_o,

    output logic                     mem_req_o,
    output core_data_pkg::mem_req_t  mem_req_data_o,
    input  core_data_pkg::mem_rsp_t  mem_rsp_i
);

    // Round-robin pointer, set when ext won last
    logic last_ext_q;
    // Owner of the transfer whose response is due
    logic owner_ext_q;

    assign core_gnt_o = core_req_i & (~ext_req_i | last_ext_q);
    assign ext_gnt_o  = ext_req_i & (~core_req_i | ~last_ext_q);

    assign mem_req_o      = core_gnt_o | ext_gnt_o;
    assign mem_req_data_o = ext_gnt_o ? ext_req_data_i : core_req_data_i;

    // Read data goes to both, rvalid only to the owner
    always_comb begin
        core_rsp_o        = mem_rsp_i;
        ext_rsp_o         = mem_rsp_i;
        core_rsp_o.rvalid = mem_rsp_i.rvalid & ~owner_ext_q;
        ext_rsp_o.rvalid  = mem_rsp_i.rvalid & owner_ext_q;
    end

    always_ff @(posedge clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            last_ext_q  <= 1'b1;
            owner_ext_q <= 1'b0;
        end else begin
            owner_ext_q <= ext_gnt_o;
            if (mem_req_o) begin
                last_ext_q <= ext_gnt_o;
            end
        end
    end

    a_one_grant: assert property (@(posedge clk_i) disable iff (!reset_ni)
        !(core_gnt_o && ext_gnt_o))
        else $error("sram_arbiter: both masters granted");

endmodule

`default_nettype wire

//--- hw/data_sram.sv
`timescale 1ns/10ps
`default_nettype none

module data_sram (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  logic                     req_i,
    input  core_data_pkg::mem_req_t  req_data_i,
    output core_data_pkg::mem_rsp_t  rsp_o
);
    import core_data_pkg::*;

    localparam int OFF_W = $clog2(BE_W);

    data_t                 mem_q [SRAM_WORDS];
    logic [SRAM_IDX_W-1:0] idx;
    logic                  rvalid_q;
    data_t                 rdata_q;

    // Word index above the byte offset
    assign idx = req_data_i.addr[OFF_W +: SRAM_IDX_W];

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_q <= mem_q[idx];
            if (req_data_i.we) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (req_data_i.be[b]) begin
                        mem_q[idx][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // Every request answered next cycle
    always_ff @(posedge clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i;
        end
    end

    always_comb begin
        rsp_o.rvalid = rvalid_q;
        rsp_o.rdata  = rdata_q;
    end

endmodule

`default_nettype wire

//--- hw/core_data_pkg.sv
`default_nettype none

package core_data_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BE_W-1:0]   be_t;

    ////////////////////////////////////////////////////////////////////////////
    // Address map

    localparam addr_t SRAM_BASE  = 32'h0000_0000;
    localparam addr_t SRAM_SIZE  = 32'h0000_2000;
    localparam int    SRAM_WORDS = int'(SRAM_SIZE) / BE_W;
    localparam int    SRAM_IDX_W = $clog2(SRAM_WORDS);

    localparam addr_t APB_BASE   = 32'h1000_0000;
    localparam addr_t APB_LIMIT  = 32'h1000_FFFF;

    typedef enum logic [1:0] {
        REGION_SRAM,
        REGION_APB,
        REGION_ILLEGAL
    } region_e;

    // Request side of the memory protocol
    typedef struct packed {
        addr_t addr;
        logic  we;
        be_t   be;
        data_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  rvalid;
        data_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        addr_t paddr;
        logic  pwrite;
        data_t pwdata;
        be_t   pstrb;
    } apb_req_t;

endpackage

`default_nettype wire
